/* design/uart_frame_pkg.sv */
package uart_frame_pkg;

  // ------------------------------
  // Frame format
  // ------------------------------

  localparam int data_bits  = 8;
  localparam int frame_bits = 1 + data_bits + 1 + 1; // Start, data, parity, stop.

  typedef logic [data_bits-1:0] frame_byte_t;

  // ------------------------------
  // Parity rule
  // ------------------------------

  // Odd parity, so data ones plus the parity bit give an odd count.
  function automatic logic odd_parity(frame_byte_t data);
    return ~(^data);
  endfunction

endpackage

/* design/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // ------------------------------
  // Address byte layout
  // ------------------------------

  localparam int addr_write_flag = 7; // Set on the address byte of a write.

  // ------------------------------
  // Host side payloads
  // ------------------------------

  typedef struct packed {
    logic                        write;
    logic [6:0]                  addr;
    uart_frame_pkg::frame_byte_t data;
  } uart_cmd_t;

  typedef struct packed {
    uart_frame_pkg::frame_byte_t data;
    logic                        parity_err;
    logic                        frame_err;
    logic                        timeout;   // No start bit seen in time.
  } uart_rsp_t;

endpackage

/* design/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit = 434
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        tx_start,
  input  uart_frame_pkg::frame_byte_t tx_byte,
  output logic                        tx,
  output logic                        tx_busy
);

  localparam int cnt_w   = $clog2(clks_per_bit);
  localparam int idx_w   = $clog2(uart_frame_pkg::frame_bits);
  localparam int shift_w = uart_frame_pkg::frame_bits - 1;
  localparam int last_idx = uart_frame_pkg::frame_bits - 1;

  logic [cnt_w-1:0]   bit_cnt;
  logic [idx_w-1:0]   bit_idx;
  logic [shift_w-1:0] shift_q; // Data, parity and stop still to go.
  logic               bit_end;

  assign bit_end = (bit_cnt == cnt_w'(clks_per_bit - 1));

  // ------------------------------
  // Bit timing and line drive
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
    end
    else if (!tx_busy)
    begin
      bit_cnt <= '0;
      bit_idx <= '0;
      if (tx_start)
      begin
        tx      <= 1'b0; // Start bit.
        tx_busy <= 1'b1;
      end
    end
    else if (bit_end)
    begin
      bit_cnt <= '0;
      if (bit_idx == idx_w'(last_idx))
      begin
        tx      <= 1'b1;
        tx_busy <= 1'b0; // Stop bit done.
      end
      else
      begin
        tx      <= shift_q[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end
    else
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (tx_start && !tx_busy)
      shift_q <= {1'b1, uart_frame_pkg::odd_parity(tx_byte), tx_byte};
    else if (tx_busy && bit_end)
      shift_q <= {1'b1, shift_q[shift_w-1:1]}; // LSB first.
  end

  // ------------------------------
  // Checks
  // ------------------------------

  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy
  );

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
  parameter int clks_per_bit = 434
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx,
  input  logic                        rx_en,
  output uart_frame_pkg::frame_byte_t rx_byte,
  output logic                        rx_vld,
  output logic                        rx_parity_err,
  output logic                        rx_frame_err
);

  localparam int cnt_w    = $clog2(clks_per_bit);
  localparam int idx_w    = $clog2(uart_frame_pkg::frame_bits);
  localparam int par_idx  = uart_frame_pkg::data_bits + 1;
  localparam int stop_idx = uart_frame_pkg::frame_bits - 1;

  logic                        rx_meta;
  logic                        rx_sync;
  logic                        rx_prev;
  logic                        fall;
  logic                        active;
  logic                        sample;
  logic [cnt_w-1:0]            cnt;
  logic [idx_w-1:0]            bit_idx;
  uart_frame_pkg::frame_byte_t data_q;
  logic                        par_q;

  assign fall   = rx_prev && !rx_sync;
  assign sample = active && (cnt == '0); // Mid-bit point.

  // ------------------------------
  // Sync, start detect, bit timing
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
      active  <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
      rx_vld  <= 1'b0;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      rx_vld  <= 1'b0;
      if (!active)
      begin
        if (rx_en && fall)
        begin
          active  <= 1'b1;
          cnt     <= cnt_w'(clks_per_bit / 2 - 1); // Half a bit to mid-start.
          bit_idx <= '0;
        end
      end
      else if (!sample)
      begin
        cnt <= cnt - 1'b1;
      end
      else
      begin
        cnt <= cnt_w'(clks_per_bit - 1);
        if (bit_idx == '0 && rx_sync)
        begin
          active <= 1'b0; // Line high again, a glitch.
        end
        else if (bit_idx == idx_w'(stop_idx))
        begin
          active <= 1'b0;
          rx_vld <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // Data capture and error checks
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx == idx_w'(stop_idx))
      begin
        rx_byte       <= data_q;
        rx_parity_err <= (par_q != uart_frame_pkg::odd_parity(data_q));
        rx_frame_err  <= !rx_sync; // Stop bit must be high.
      end
      else if (bit_idx == idx_w'(par_idx))
      begin
        par_q <= rx_sync;
      end
      else if (bit_idx != '0)
      begin
        data_q <= {rx_sync, data_q[uart_frame_pkg::data_bits-1:1]};
      end
    end
  end

  a_rx_vld_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_vld |=> !rx_vld
  );

endmodule

/* design/uart_cmd_ctrl.sv */
`timescale 1ns/1ps

module uart_cmd_ctrl #(
  parameter int gap_clks         = 100,
  parameter int clks_per_bit     = 434,
  parameter int rsp_timeout_bits = 32
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  uart_cmd_pkg::uart_cmd_t     cmd,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  output uart_cmd_pkg::uart_rsp_t     rsp,
  output logic                        rsp_vld,
  output logic                        tx_start,
  output uart_frame_pkg::frame_byte_t tx_byte,
  input  logic                        tx_busy,
  output logic                        rx_en,
  input  uart_frame_pkg::frame_byte_t rx_byte,
  input  logic                        rx_vld,
  input  logic                        rx_parity_err,
  input  logic                        rx_frame_err
);

  localparam int gap_w  = $clog2(gap_clks);
  localparam int tick_w = $clog2(clks_per_bit);
  localparam int to_w   = $clog2(rsp_timeout_bits);

  typedef enum logic [2:0] {
    st_idle,
    st_send_addr,
    st_wait_addr,
    st_gap,
    st_send_data,
    st_wait_data,
    st_listen,
    st_respond
  } state_t;

  state_t                  state;
  state_t                  state_nxt;
  uart_cmd_pkg::uart_cmd_t cmd_q;
  uart_cmd_pkg::uart_rsp_t rsp_q;
  logic [gap_w-1:0]        gap_cnt;
  logic [tick_w-1:0]       tick_cnt;
  logic [to_w-1:0]         to_bits;
  logic                    gap_done;
  logic                    tick_last;
  logic                    rsp_timeout;
  logic                    rsp_hit;

  assign cmd_rdy     = (state == st_idle);
  assign rsp_vld     = (state == st_respond);
  assign tx_start    = (state == st_send_addr) || (state == st_send_data);
  assign gap_done    = (gap_cnt == gap_w'(gap_clks - 1));
  assign tick_last   = (tick_cnt == tick_w'(clks_per_bit - 1));
  assign rsp_timeout = (state == st_listen) && tick_last
                       && (to_bits == to_w'(rsp_timeout_bits - 1));
  assign rsp_hit     = rx_en && rx_vld;
  assign rsp         = rsp_q;

  // Listen from the address frame on since the slave may answer early.
  assign rx_en = !cmd_q.write && ((state == st_wait_addr) || (state == st_gap)
                                  || (state == st_listen));

  always_comb
  begin
    tx_byte = cmd_q.data;
    if (state == st_send_addr)
    begin
      tx_byte = uart_frame_pkg::frame_byte_t'(cmd_q.addr);
      tx_byte[uart_cmd_pkg::addr_write_flag] = cmd_q.write;
    end
  end

  // ------------------------------
  // FSM
  // ------------------------------

  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle:      if (cmd_vld) state_nxt = st_send_addr;
      st_send_addr: state_nxt = st_wait_addr;
      st_wait_addr:
      begin
        if (rsp_hit)
          state_nxt = st_respond;
        else if (!tx_busy)
          state_nxt = st_gap;
      end
      st_gap:
      begin
        if (rsp_hit)
          state_nxt = st_respond;
        else if (gap_done)
          state_nxt = cmd_q.write ? st_send_data : st_listen;
      end
      st_send_data: state_nxt = st_wait_data;
      st_wait_data: if (!tx_busy) state_nxt = st_idle;
      st_listen:    if (rsp_hit || rsp_timeout) state_nxt = st_respond;
      st_respond:   state_nxt = st_idle;
      default:      state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      gap_cnt  <= '0;
      tick_cnt <= '0;
      to_bits  <= '0;
    end
    else
    begin
      state   <= state_nxt;
      gap_cnt <= (state == st_gap) ? gap_cnt + 1'b1 : '0;
      if (state != st_listen || tick_last)
        tick_cnt <= '0;
      else
        tick_cnt <= tick_cnt + 1'b1;
      if (state != st_listen)
        to_bits <= '0;
      else if (tick_last)
        to_bits <= to_bits + 1'b1; // One more bit time without a start.
    end
  end

  // ------------------------------
  // Command and response holding
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd;
    if (rsp_hit)
    begin
      rsp_q.data       <= rx_byte;
      rsp_q.parity_err <= rx_parity_err;
      rsp_q.frame_err  <= rx_frame_err;
      rsp_q.timeout    <= 1'b0;
    end
    else if (rsp_timeout)
    begin
      rsp_q <= '{data: '0, parity_err: 1'b0, frame_err: 1'b0, timeout: 1'b1};
    end
  end

  a_no_rsp_for_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy && cmd.write) |=> !rsp_vld until cmd_rdy
  );

  a_busy_not_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_busy |-> !cmd_rdy
  );

endmodule

/* design/uart_cmd_master.sv */
`timescale 1ns/1ps

module uart_cmd_master #(
  parameter int clks_per_bit     = 434,
  parameter int gap_clks         = 100,
  parameter int rsp_timeout_bits = 32
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::uart_cmd_t cmd,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  output uart_cmd_pkg::uart_rsp_t rsp,
  output logic                    rsp_vld,
  output logic                    tx,
  input  logic                    rx
);

  logic                        tx_start;
  uart_frame_pkg::frame_byte_t tx_byte;
  logic                        tx_busy;
  logic                        rx_en;
  uart_frame_pkg::frame_byte_t rx_byte;
  logic                        rx_vld;
  logic                        rx_parity_err;
  logic                        rx_frame_err;

  uart_cmd_ctrl #(
    .gap_clks         (gap_clks),
    .clks_per_bit     (clks_per_bit),
    .rsp_timeout_bits (rsp_timeout_bits)
  ) u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd           (cmd),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .rsp           (rsp),
    .rsp_vld       (rsp_vld),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .rx_en         (rx_en),
    .rx_byte       (rx_byte),
    .rx_vld        (rx_vld),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

  uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx #(.clks_per_bit(clks_per_bit)) u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_en         (rx_en),
    .rx_byte       (rx_byte),
    .rx_vld        (rx_vld),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

/* tests/tb_uart_cmd_master.sv */
`timescale 1ns/1ps

module tb_uart_cmd_master;

  localparam int clks_per_bit     = 8;
  localparam int gap_clks         = 20;
  localparam int rsp_timeout_bits = 24;
  localparam int n_cmds           = 60;
  localparam int frame_clks       = 11 * clks_per_bit;
  // Worst command is a silent read plus slack for a late response and handshakes.
  localparam int worst_cmd_clks   = 2 * frame_clks + 2 * gap_clks
                                    + (rsp_timeout_bits + 10) * clks_per_bit + 20;
  localparam int max_cycles       = 20 + n_cmds * worst_cmd_clks;

  logic                    clk;
  logic                    rst_n;
  uart_cmd_pkg::uart_cmd_t cmd;
  logic                    cmd_vld;
  logic                    cmd_rdy;
  uart_cmd_pkg::uart_rsp_t rsp;
  logic                    rsp_vld;
  logic                    tx;
  logic                    rx;

  integer                  seed = 32'h4513_f699;
  int                      error_cnt;
  int                      accepted;
  int                      completed;
  int                      n_writes;
  int                      n_reads;
  int                      n_timeouts;
  int                      n_par_errs;
  int                      cycle_cnt;
  logic [7:0]              mem [128]; // Slave register memory.
  uart_cmd_pkg::uart_cmd_t sent_q[$]; // Accepted but not yet seen on tx.
  uart_cmd_pkg::uart_rsp_t exp_q[$];  // Reads awaiting rsp_vld.

  uart_cmd_master #(
    .clks_per_bit     (clks_per_bit),
    .gap_clks         (gap_clks),
    .rsp_timeout_bits (rsp_timeout_bits)
  ) dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .rsp     (rsp),
    .rsp_vld (rsp_vld),
    .tx      (tx),
    .rx      (rx)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected)
    begin
      error_cnt++;
      $display("MISMATCH t=%0t %s: got 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
    end
  endtask

  task automatic finish_run();
    $display("Done: %0d errors, %0d writes, %0d reads, %0d timeouts, %0d parity errors",
             error_cnt, n_writes, n_reads, n_timeouts, n_par_errs);
    if (error_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  endtask

  // Slave receiver sampling tx at mid-bit.
  task automatic receive_frame(input string what, output logic [7:0] data);
    logic [10:0] bits;
    int          i;
    @(posedge clk);
    while (tx !== 1'b0)
      @(posedge clk);
    repeat (clks_per_bit / 2 - 1) @(posedge clk);
    bits[0] = tx;
    for (i = 1; i < 11; i++)
    begin
      repeat (clks_per_bit) @(posedge clk);
      bits[i] = tx;
    end
    data = bits[8:1];
    compare_value({what, " start bit"}, bits[0], 1'b0);
    compare_value({what, " parity bit"}, bits[9], ~^bits[8:1]); // Odd ones in total.
    compare_value({what, " stop bit"}, bits[10], 1'b1);
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [10:0] bits;
    int          i;
    bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
    for (i = 0; i < 11; i++)
    begin
      rx <= bits[i];
      repeat (clks_per_bit) @(posedge clk);
    end
  endtask

  // ------------------------------
  // Serial slave model
  // ------------------------------

  initial
  begin : slave
    uart_cmd_pkg::uart_cmd_t c;
    uart_cmd_pkg::uart_rsp_t e;
    logic [7:0]              addr_byte;
    logic [7:0]              data_byte;
    logic                    silent;
    logic                    bad_par;
    int                      delay;
    int                      a;
    rx = 1'b1;
    for (a = 0; a < 128; a++)
      mem[a] = 8'(a * 37 + 11);
    wait (rst_n === 1'b1);
    forever
    begin
      receive_frame("tx address", addr_byte);
      if (sent_q.size() == 0)
      begin
        error_cnt++;
        $display("Frame on tx with no accepted command at t=%0t", $time);
      end
      else
      begin
        c = sent_q.pop_front();
        compare_value("tx address byte", addr_byte, {c.write, c.addr});
        if (c.write)
        begin
          receive_frame("tx data", data_byte);
          compare_value("tx data byte", data_byte, c.data);
          mem[c.addr] = data_byte;
          completed++;
        end
        else
        begin
          silent  = (($random(seed) & 7) == 0);
          bad_par = (($random(seed) & 7) == 0);
          delay   = $unsigned($random(seed)) % 11;
          e.data       = silent ? 8'h00 : mem[c.addr];
          e.parity_err = !silent && bad_par;
          e.frame_err  = 1'b0;
          e.timeout    = silent;
          exp_q.push_back(e);
          if (!silent)
          begin
            repeat (delay * clks_per_bit) @(posedge clk);
            send_frame(mem[c.addr], bad_par);
          end
        end
      end
    end
  end

  // ------------------------------
  // Handshake and response monitor
  // ------------------------------

  always @(posedge clk)
  begin : monitor
    uart_cmd_pkg::uart_rsp_t e;
    if (rst_n)
    begin
      if (cmd_rdy && accepted != completed)
      begin
        error_cnt++;
        $display("cmd_rdy high while command %0d is still in progress at t=%0t",
                 completed, $time);
      end
      if (cmd_vld && cmd_rdy)
      begin
        sent_q.push_back(cmd);
        accepted++;
        if (cmd.write)
          n_writes++;
        else
          n_reads++;
      end
      if (rsp_vld)
      begin
        if (exp_q.size() == 0)
        begin
          error_cnt++;
          $display("rsp_vld with no read outstanding at t=%0t", $time);
        end
        else
        begin
          e = exp_q.pop_front();
          compare_value("rsp.data", rsp.data, e.data);
          compare_value("rsp.parity_err", rsp.parity_err, e.parity_err);
          compare_value("rsp.frame_err", rsp.frame_err, e.frame_err);
          compare_value("rsp.timeout", rsp.timeout, e.timeout);
          n_timeouts += e.timeout;
          n_par_errs += e.parity_err;
          completed++;
        end
      end
    end
  end

  // ------------------------------
  // Host driver
  // ------------------------------

  initial
  begin : driver
    uart_cmd_pkg::uart_cmd_t next_cmd;
    int                      n;
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    compare_value("tx after reset", tx, 1'b1);
    compare_value("cmd_rdy after reset", cmd_rdy, 1'b1);
    compare_value("rsp_vld after reset", rsp_vld, 1'b0);
    for (n = 0; n < n_cmds; n++)
    begin
      next_cmd = 16'($random(seed));
      cmd     <= next_cmd;
      cmd_vld <= 1'b1; // Held high across commands.
      @(posedge clk);
      while (!cmd_rdy)
        @(posedge clk);
    end
    cmd_vld <= 1'b0;
    while (completed < n_cmds)
      @(posedge clk);
    repeat (4 * clks_per_bit) @(posedge clk);
    compare_value("cmd_rdy after last command", cmd_rdy, 1'b1);
    compare_value("tx after last command", tx, 1'b1);
    finish_run();
  end

  initial
  begin : watchdog
    wait (cycle_cnt >= max_cycles);
    error_cnt++;
    $display("Timeout: commands did not complete within %0d cycles", max_cycles);
    finish_run();
  end

endmodule

/* uart_cmd_master.f */
design/uart_frame_pkg.sv
design/uart_cmd_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_cmd_ctrl.sv
design/uart_cmd_master.sv
tests/tb_uart_cmd_master.sv
